//--- files.f
hw/recip_pkg.sv
hw/mant_if.sv
hw/delay_line.sv
hw/pipe_mult.sv
hw/seed_lut.sv
hw/newton_step.sv
hw/fp_classify.sv
hw/recip_core.sv
hw/result_pack.sv
hw/recip_top.sv
bench/recip_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= recip_tb
FILELIST ?= files.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --assert --timescale 1ns/1ns -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf $(OBJ_DIR)

//--- bench/recip_tb.sv
`timescale 1ns/1ns

module recip_tb;

    localparam int latency = 17;
    // about 1800 operands plus a drain of 17 per batch
    localparam int max_cycles = 20000;
    // the Q1.23 estimate holds one bit less than the mantissa and each iteration rounds twice
    localparam real ulp_tol = 6.0;

    logic        clk;
    logic        rst;
    logic        in_valid;
    logic [31:0] operand;
    logic [2:0]  rounding_mode;
    logic [31:0] result;
    logic        underflow;
    logic        inexact;
    logic        invalid;
    logic        out_valid;

    // each output entry is {underflow, inexact, invalid, result}
    logic [34:0] out_q [$];
    logic [34:0] exp_q [$];
    logic [31:0] op_q [$];
    logic [2:0]  rm_q [$];
    int          in_cycle_q [$];
    int          cycle;
    int          checks;
    int          errors;
    int          test_err_start;

    recip_top recip_top_i (
        .clk(clk), .rst(rst), .in_valid(in_valid), .operand(operand),
        .rounding_mode(rounding_mode), .result(result), .underflow(underflow),
        .inexact(inexact), .invalid(invalid), .out_valid(out_valid)
    );

    always #50 clk = ~clk;

    // cycle count, timeout, latency and output capture
    always @(posedge clk) begin
        int start;
        cycle = cycle + 1;
        if (cycle > max_cycles) begin
            $display("run stopped: no end of test after %0d cycles", max_cycles);
            $display("Simulation finished: FAIL");
            $finish;
        end
        if (!rst && in_valid) begin
            in_cycle_q.push_back(cycle);
        end
        if (!rst && out_valid) begin
            checks++;
            if (in_cycle_q.size() == 0) begin
                errors++;
                $display("ERROR latency: out_valid rose with no operand in flight");
            end else begin
                start = in_cycle_q.pop_front();
                if (cycle - start != latency) begin
                    errors++;
                    $display("ERROR latency: expected %0d actual %0d", latency, cycle - start);
                end
            end
            out_q.push_back({underflow, inexact, invalid, result});
        end
    end

    function automatic real pow2(input int k);
        real v;
        v = 1.0;
        for (int i = 0; i < k; i++) begin
            v = v * 2.0;
        end
        for (int i = 0; i > k; i--) begin
            v = v / 2.0;
        end
        return v;
    endfunction

    function automatic real to_real(input logic [31:0] w);
        real mag;
        if (w[30:23] == 8'd0) begin
            mag = 0.0;
        end else begin
            mag = (1.0 + real'(w[22:0]) / 8388608.0) * pow2(int'(w[30:23]) - 127);
        end
        return w[31] ? -mag : mag;
    endfunction

    task automatic start_test();
        op_q.delete();
        rm_q.delete();
        exp_q.delete();
        test_err_start = errors;
    endtask

    task automatic expect_op(input logic [31:0] op, input logic [2:0] rm,
                             input logic [34:0] expected);
        op_q.push_back(op);
        rm_q.push_back(rm);
        exp_q.push_back(expected);
    endtask

    // back-to-back operands, then wait for every result
    task automatic drive_batch();
        int n;
        n = op_q.size();
        out_q.delete();
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            in_valid <= 1'b1;
            operand <= op_q[i];
            rounding_mode <= rm_q[i];
        end
        @(posedge clk);
        in_valid <= 1'b0;
        while (out_q.size() < n) begin
            @(posedge clk);
        end
    endtask

    task automatic check_all(input string name);
        for (int i = 0; i < exp_q.size(); i++) begin
            checks++;
            if (out_q[i] !== exp_q[i]) begin
                errors++;
                $display("ERROR %s: expected %h actual %h", name, exp_q[i], out_q[i]);
            end
        end
    endtask

    task automatic report(input string name, input int n);
        $display("%s done: %0d operands, %0d errors", name, n, errors - test_err_start);
    endtask

    task automatic test_latency();
        int n;
        start_test();
        expect_op(32'h4000_0000, 3'd0, {3'b000, 32'h3f00_0000});
        drive_batch();
        check_all("latency");
        n = op_q.size();
        op_q.delete();
        rm_q.delete();
        exp_q.delete();
        // distinct results show the order of the burst
        for (int j = 1; j <= 8; j++) begin
            expect_op({1'b0, 8'(127 + j), 23'd0}, 3'(j % 5), {3'b000, 1'b0, 8'(127 - j), 23'd0});
        end
        drive_batch();
        check_all("latency");
        report("latency", n + op_q.size());
    endtask

    task automatic test_specials();
        start_test();
        for (int m = 0; m < 5; m++) begin
            expect_op(32'h7fc1_2345, 3'(m), {3'b000, 32'h7fc1_2345});
            expect_op(32'hff81_2345, 3'(m), {3'b001, 32'hffc1_2345});
            expect_op(32'h7f80_0000, 3'(m), {3'b000, 32'h0000_0000});
            expect_op(32'hff80_0000, 3'(m), {3'b000, 32'h8000_0000});
            expect_op(32'h0000_0000, 3'(m), {3'b000, 32'h7f80_0000});
            expect_op(32'h8000_0000, 3'(m), {3'b000, 32'hff80_0000});
            expect_op(32'h0000_0123, 3'(m), {3'b100, 32'h7f80_0000});
            expect_op(32'h8040_0000, 3'(m), {3'b100, 32'hff80_0000});
        end
        drive_batch();
        check_all("specials");
        report("specials", op_q.size());
    endtask

    task automatic test_powers();
        start_test();
        for (int m = 0; m < 5; m++) begin
            for (int k = -126; k <= 126; k++) begin
                expect_op({1'b0, 8'(k + 127), 23'd0}, 3'(m), {3'b000, 1'b0, 8'(127 - k), 23'd0});
            end
        end
        drive_batch();
        check_all("powers");
        report("powers", op_q.size());
    endtask

    task automatic test_underflow();
        logic [22:0] f;
        start_test();
        for (int m = 0; m < 5; m++) begin
            for (int s = 0; s < 2; s++) begin
                f = 23'($urandom);
                expect_op({1'(s), 8'd254, f}, 3'(m), {3'b110, 1'(s), 31'd0});
                if (f == 23'd0) begin
                    f = 23'd1;
                end
                expect_op({1'(s), 8'd253, f}, 3'(m), {3'b110, 1'(s), 31'd0});
            end
        end
        drive_batch();
        check_all("underflow");
        report("underflow", op_q.size());
    endtask

    task automatic test_random();
        logic [22:0] f;
        logic [34:0] act_w;
        real         recip;
        real         act;
        real         diff;
        real         ulp;
        start_test();
        for (int m = 0; m < 5; m++) begin
            for (int i = 0; i < 100; i++) begin
                f = 23'($urandom);
                // a zero fraction is a power of two, covered elsewhere
                if (f == 23'd0) begin
                    f = 23'd1;
                end
                expect_op({1'($urandom), 8'($urandom_range(252, 1)), f}, 3'(m), 35'd0);
            end
        end
        drive_batch();
        for (int i = 0; i < op_q.size(); i++) begin
            act_w = out_q[i];
            recip = 1.0 / to_real(op_q[i]);
            act = to_real(act_w[31:0]);
            ulp = pow2(103 - int'(op_q[i][30:23]));
            diff = act - recip;
            if (diff < 0.0) begin
                diff = -diff;
            end
            checks++;
            if (diff > ulp_tol * ulp) begin
                errors++;
                $display("ERROR random: expected %e actual %e (operand %h mode %0d)",
                         recip, act, op_q[i], rm_q[i]);
            end
            if (act != recip && !act_w[33]) begin
                errors++;
                $display("ERROR random: expected inexact 1 actual 0 (operand %h)", op_q[i]);
            end
            if (act_w[34] || act_w[32]) begin
                errors++;
                $display("ERROR random: expected underflow 0 invalid 0 actual %b %b",
                         act_w[34], act_w[32]);
            end
        end
        report("random", op_q.size());
    endtask

    initial begin
        void'($urandom(32'h2a78));
        clk = 1'b0;
        rst = 1'b1;
        in_valid = 1'b0;
        operand = 32'd0;
        rounding_mode = 3'd0;
        cycle = 0;
        checks = 0;
        errors = 0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        checks++;
        if ({out_valid, underflow, inexact, invalid, result} !== 36'd0) begin
            errors++;
            $display("ERROR reset: expected %h actual %h", 36'd0,
                     {out_valid, underflow, inexact, invalid, result});
        end
        test_latency();
        test_specials();
        test_powers();
        test_underflow();
        test_random();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- hw/recip_top.sv
`timescale 1ns/1ns

module recip_top (
    input  logic        clk,
    input  logic        rst,
    input  logic        in_valid,
    input  logic [31:0] operand,
    input  logic [2:0]  rounding_mode,
    output logic [31:0] result,
    output logic        underflow,
    output logic        inexact,
    output logic        invalid,
    output logic        out_valid
);
    import recip_pkg::*;

    mant_if req_bus ();
    mant_if res_bus ();

    side_t            side_c, side_d;
    logic [exp_w-1:0] exp_c, exp_d;

    fp_classify classify_i (
        .clk(clk), .rst(rst), .in_valid(in_valid), .operand(operand),
        .rounding_mode(rm_t'(rounding_mode)), .req(req_bus.src),
        .side(side_c), .new_exp(exp_c)
    );

    // sideband rides past the core
    delay_line #(.payload_t(side_t), .depth(core_lat)) side_dly_i (
        .clk(clk), .rst(rst), .d(side_c), .q(side_d)
    );
    delay_line #(.payload_t(logic [exp_w-1:0]), .depth(core_lat)) exp_dly_i (
        .clk(clk), .rst(rst), .d(exp_c), .q(exp_d)
    );

    recip_core core_i (.clk(clk), .rst(rst), .req(req_bus.dst), .res(res_bus.src));

    result_pack pack_i (
        .clk(clk), .rst(rst), .res(res_bus.dst), .side(side_d), .new_exp(exp_d),
        .result(result), .underflow(underflow), .inexact(inexact),
        .invalid(invalid), .out_valid(out_valid)
    );

endmodule

//--- hw/result_pack.sv
`timescale 1ns/1ns

module result_pack (
    input  logic             clk,
    input  logic             rst,
    mant_if.dst              res,
    input  recip_pkg::side_t side,
    input  logic [7:0]       new_exp,
    output logic [31:0]      result,
    output logic             underflow,
    output logic             inexact,
    output logic             invalid,
    output logic             out_valid
);
    import recip_pkg::*;

    logic [fix_w:0]    rounded;
    logic [frac_w-1:0] frac_r;
    logic [exp_w-1:0]  exp_r;
    logic              tail;

    always_comb begin
        tail = res.guard | res.round | res.sticky;
        rounded = round_q123(res.mant, res.guard, res.round, res.sticky, res.sign, res.rm);
        // mantissa rolled over to 2.0
        if (rounded[fix_w]) begin
            frac_r = '0;
            exp_r = new_exp + 8'd1;
        end else begin
            frac_r = rounded[frac_w-1:0];
            exp_r = new_exp;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            result <= '0;
            underflow <= 1'b0;
            inexact <= 1'b0;
            invalid <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= res.valid;
            invalid <= side.invalid;
            if (side.special) begin
                result <= side.special_result;
                underflow <= side.flushed;
                inexact <= 1'b0;
            end else if (new_exp == '0) begin
                // too small for a normal, signed zero
                result <= {side.sign, 31'd0};
                underflow <= 1'b1;
                inexact <= 1'b1;
            end else begin
                result <= {res.sign, exp_r, frac_r};
                underflow <= 1'b0;
                inexact <= tail;
            end
        end
    end

    // sideband delay must line up with the core result
    assert property (@(posedge clk) disable iff (rst)
        res.valid |-> (res.sign == side.sign) && (res.rm == side.rm));

endmodule

//--- hw/recip_core.sv
`timescale 1ns/1ns

module recip_core (
    input  logic clk,
    input  logic rst,
    mant_if.dst  req,
    mant_if.src  res
);
    import recip_pkg::*;

    logic [fix_w-1:0] a_in, a_d1, a_d8;
    logic [fix_w-1:0] seed, x1, x2;
    logic [3:0]       ctl_d1, ctl_d8, ctl_d15;
    logic [1:0]       flags_out;

    // hidden one back in front of the fraction
    assign a_in = {1'b1, req.mant[frac_w-1:0]};

    seed_lut seed_i (
        .clk(clk), .rst(rst), .idx(req.mant[frac_w-1 -: lut_bits]), .seed(seed)
    );

    delay_line #(.payload_t(logic [fix_w-1:0]), .depth(1)) a_dly1_i (
        .clk(clk), .rst(rst), .d(a_in), .q(a_d1)
    );
    delay_line #(.payload_t(logic [fix_w-1:0]), .depth(newton_lat)) a_dly8_i (
        .clk(clk), .rst(rst), .d(a_d1), .q(a_d8)
    );

    // {sign, mode} follows each iteration
    delay_line #(.payload_t(logic [3:0]), .depth(1)) ctl_dly1_i (
        .clk(clk), .rst(rst), .d({req.sign, req.rm}), .q(ctl_d1)
    );
    delay_line #(.payload_t(logic [3:0]), .depth(newton_lat)) ctl_dly8_i (
        .clk(clk), .rst(rst), .d(ctl_d1), .q(ctl_d8)
    );
    delay_line #(.payload_t(logic [3:0]), .depth(newton_lat)) ctl_dly15_i (
        .clk(clk), .rst(rst), .d(ctl_d8), .q(ctl_d15)
    );

    // valid and mantissa-is-one over the full core latency
    delay_line #(.payload_t(logic [1:0]), .depth(core_lat)) flag_dly_i (
        .clk(clk), .rst(rst), .d({req.valid, req.mant[frac_w-1:0] == '0}), .q(flags_out)
    );

    newton_step step1_i (
        .clk(clk), .rst(rst), .a(a_d1), .x(seed),
        .rm(rm_t'(ctl_d1[2:0])), .sign(ctl_d1[3]), .x_next(x1)
    );
    newton_step step2_i (
        .clk(clk), .rst(rst), .a(a_d8), .x(x1),
        .rm(rm_t'(ctl_d8[2:0])), .sign(ctl_d8[3]), .x_next(x2)
    );

    // x2 sits in (0.5,1], the mantissa of 1/a is 2*x2 unless a is one
    always_comb begin
        res.valid = flags_out[1];
        res.sign = ctl_d15[3];
        res.rm = rm_t'(ctl_d15[2:0]);
        res.guard = 1'b0;
        res.round = 1'b0;
        if (flags_out[0]) begin
            res.mant = {1'b1, {frac_w{1'b0}}};
            res.sticky = 1'b0;
        end else if (x2[fix_w-1]) begin
            // estimate rounded up to one, keep the largest mantissa
            res.mant = '1;
            res.sticky = 1'b1;
        end else begin
            res.mant = {x2[fix_w-2:0], 1'b0};
            // the tail under the estimate is never zero here
            res.sticky = 1'b1;
        end
    end

endmodule

//--- hw/fp_classify.sv
`timescale 1ns/1ns

module fp_classify (
    input  logic             clk,
    input  logic             rst,
    input  logic             in_valid,
    input  logic [31:0]      operand,
    input  recip_pkg::rm_t   rounding_mode,
    mant_if.src              req,
    output recip_pkg::side_t side,
    output logic [7:0]       new_exp
);
    import recip_pkg::*;

    logic              sgn;
    logic [exp_w-1:0]  ex;
    logic [frac_w-1:0] fr;
    logic              is_zero, is_inf, is_qnan, is_snan, is_denorm;
    logic [exp_w:0]    exp_diff;
    side_t             side_c;

    assign {sgn, ex, fr} = operand;

    always_comb begin
        is_zero = (ex == '0) && (fr == '0);
        is_denorm = (ex == '0) && (fr != '0);
        is_inf = (ex == '1) && (fr == '0);
        is_qnan = (ex == '1) && (fr != '0) && fr[frac_w-1];
        is_snan = (ex == '1) && (fr != '0) && !fr[frac_w-1];

        side_c.sign = sgn;
        side_c.rm = rounding_mode;
        side_c.special = is_zero | is_denorm | is_inf | is_qnan | is_snan;
        side_c.invalid = is_snan;
        side_c.flushed = is_denorm;
        if (is_qnan) begin
            side_c.special_result = operand;
        end else if (is_snan) begin
            // set the quiet bit
            side_c.special_result = operand | 32'h0040_0000;
        end else if (is_inf) begin
            side_c.special_result = {sgn, 31'd0};
        end else if (is_zero || is_denorm) begin
            side_c.special_result = {sgn, 8'hff, 23'd0};
        end else begin
            side_c.special_result = 32'd0;
        end

        // 1/m for m in (1,2) lands below one, hence one less
        exp_diff = ((fr == '0) ? 9'd254 : 9'd253) - {1'b0, ex};
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            req.valid <= 1'b0;
            req.mant <= '0;
            req.sign <= 1'b0;
            req.rm <= rne;
            side <= '0;
            new_exp <= '0;
        end else begin
            req.valid <= in_valid;
            req.mant <= {1'b0, fr};
            req.sign <= sgn;
            req.rm <= rounding_mode;
            side <= side_c;
            // negative means the result underflows
            new_exp <= exp_diff[exp_w] ? '0 : exp_diff[exp_w-1:0];
        end
    end

    assign req.guard = 1'b0;
    assign req.round = 1'b0;
    assign req.sticky = 1'b0;

endmodule

//--- hw/newton_step.sv
`timescale 1ns/1ns

module newton_step (
    input  logic           clk,
    input  logic           rst,
    input  logic [23:0]    a,
    input  logic [23:0]    x,
    input  recip_pkg::rm_t rm,
    input  logic           sign,
    output logic [23:0]    x_next
);
    import recip_pkg::*;

    logic [prod_w-1:0] y;
    logic [prod_w-1:0] p;
    logic [27:0]       z_full;
    logic [26:0]       z_q;
    logic [fix_w:0]    z_rnd;
    logic [fix_w:0]    x_rnd;
    logic [fix_w-1:0]  z_r;
    logic [fix_w-1:0]  x_d4;
    logic [fix_w-1:0]  a_d2;
    logic [3:0]        ctl_d3;
    logic [3:0]        ctl_d6;

    // cycles 0-2: y = a * x in Q2.46
    pipe_mult mult_y_i (.clk(clk), .rst(rst), .a(a), .b(x), .p(y));

    delay_line #(.payload_t(logic [fix_w-1:0]), .depth(2)) a_dly_i (
        .clk(clk), .rst(rst), .d(a), .q(a_d2)
    );
    delay_line #(.payload_t(logic [fix_w-1:0]), .depth(4)) x_dly_i (
        .clk(clk), .rst(rst), .d(x), .q(x_d4)
    );
    delay_line #(.payload_t(logic [3:0]), .depth(3)) ctl_dly3_i (
        .clk(clk), .rst(rst), .d({sign, rm}), .q(ctl_d3)
    );
    delay_line #(.payload_t(logic [3:0]), .depth(3)) ctl_dly6_i (
        .clk(clk), .rst(rst), .d(ctl_d3), .q(ctl_d6)
    );

    // 2 - y, three extra fraction bits feed the rounder
    assign z_full = 28'h800_0000 - y[prod_w-1:20];
    assign z_rnd = round_q123(z_q[26:3], z_q[2], z_q[1], z_q[0], ctl_d3[3], rm_t'(ctl_d3[2:0]));

    // cycles 4-6: x * z
    pipe_mult mult_x_i (.clk(clk), .rst(rst), .a(x_d4), .b(z_r), .p(p));

    assign x_rnd = round_q123(p[46:23], p[22], p[21], |p[20:0], ctl_d6[3],
                              rm_t'(ctl_d6[2:0]));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            z_q <= '0;
            z_r <= '0;
            x_next <= '0;
        end else begin
            z_q <= z_full[26:0];
            z_r <= z_rnd[fix_w-1:0];
            x_next <= x_rnd[fix_w-1:0];
        end
    end

    // a normalized a and a sane estimate keep 2 - a*x inside [0,2)
    assert property (@(posedge clk) disable iff (rst) a_d2[fix_w-1] |-> !z_full[27]);

endmodule

//--- hw/seed_lut.sv
`timescale 1ns/1ns

module seed_lut (
    input  logic        clk,
    input  logic        rst,
    input  logic [7:0]  idx,
    output logic [23:0] seed
);
    logic [23:0] rom [256];

    // entry i holds 1/(1 + (i + 0.5)/256) in Q1.23, rounded to nearest
    initial begin
        for (int i = 0; i < 256; i++) begin
            rom[i] = 24'((((64'd1 << 33) / (64'd513 + 64'(2 * i))) + 64'd1) >> 1);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            seed <= '0;
        end else begin
            seed <= rom[idx];
        end
    end

endmodule

//--- hw/pipe_mult.sv
`timescale 1ns/1ns

module pipe_mult (
    input  logic        clk,
    input  logic        rst,
    input  logic [23:0] a,
    input  logic [23:0] b,
    output logic [47:0] p
);
    logic [23:0] a_q;
    logic [23:0] b_q;

    // operands in the first stage, product in the second
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            a_q <= '0;
            b_q <= '0;
            p <= '0;
        end else begin
            a_q <= a;
            b_q <= b;
            p <= a_q * b_q;
        end
    end

endmodule

//--- hw/delay_line.sv
`timescale 1ns/1ns

module delay_line #(
    parameter type payload_t = logic,
    parameter int  depth = 1
) (
    input  logic     clk,
    input  logic     rst,
    input  payload_t d,
    output payload_t q
);
    payload_t stages [depth];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < depth; i++) begin
                stages[i] <= '0;
            end
        end else begin
            stages[0] <= d;
            for (int i = 1; i < depth; i++) begin
                stages[i] <= stages[i-1];
            end
        end
    end

    assign q = stages[depth-1];

endmodule

//--- hw/mant_if.sv
`timescale 1ns/1ns

interface mant_if;
    import recip_pkg::*;

    logic             valid;
    logic [fix_w-1:0] mant;
    logic             sign;
    rm_t              rm;
    // only meaningful on the result side
    logic             guard;
    logic             round;
    logic             sticky;

    modport src (
        output valid, mant, sign, rm, guard, round, sticky
    );

    modport dst (
        input valid, mant, sign, rm, guard, round, sticky
    );

endinterface

//--- hw/recip_pkg.sv
package recip_pkg;

    localparam int frac_w = 23;
    localparam int fix_w = 24;
    localparam int prod_w = 48;
    localparam int exp_w = 8;
    localparam int lut_bits = 8;
    localparam int newton_lat = 7;
    localparam int core_lat = 15;

    typedef enum logic [2:0] {
        rne = 3'd0,
        rtz = 3'd1,
        rdn = 3'd2,
        rup = 3'd3,
        rmm = 3'd4
    } rm_t;

    // travels beside the datapath from classify to pack
    typedef struct packed {
        logic        sign;
        rm_t         rm;
        logic        special;
        logic        invalid;
        logic        flushed;
        logic [31:0] special_result;
    } side_t;

    // bit fix_w of the result is the carry out of the mantissa
    function automatic logic [fix_w:0] round_q123(
        input logic [fix_w-1:0] value,
        input logic             guard,
        input logic             round,
        input logic             sticky,
        input logic             sign,
        input rm_t              rm
    );
        logic inc;
        logic tail;
        tail = guard | round | sticky;
        case (rm)
            rtz: inc = 1'b0;
            rdn: inc = sign & tail;
            rup: inc = ~sign & tail;
            rmm: inc = guard;
            // unknown codes fall back to nearest even
            default: inc = guard & (round | sticky | value[0]);
        endcase
        return {1'b0, value} + {{fix_w{1'b0}}, inc};
    endfunction

endpackage
